// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat hash_table.f)) rtl/hash_table_config.svh

.PHONY: all run clean

all: run

obj_dir/Vhash_table_tb: hash_table.f $(SRCS)
	verilator --binary --timing --assert --top-module hash_table_tb \
		-f hash_table.f -Mdir obj_dir

run: obj_dir/Vhash_table_tb
	./obj_dir/Vhash_table_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/hash_table_asserts.sv ====
`timescale 1ns/1ps

module hash_table_asserts (
    input logic       clk,
    input logic       reset_i,
    input logic       cyc_i,
    input logic       stb_i,
    input logic       ack_i,
    input logic [3:0] flags_i   // not found, present, no space, no target
);

    ack_single: assert property (
        @(posedge clk) disable iff (reset_i) ack_i |=> !ack_i
    ) else $error("ack held high for two cycles in a row");

    ack_in_cycle: assert property (
        @(posedge clk) disable iff (reset_i) ack_i |-> (cyc_i && stb_i)
    ) else $error("ack raised without an active cycle and strobe");

    one_flag: assert property (
        @(posedge clk) disable iff (reset_i) ack_i |-> $onehot0(flags_i)
    ) else $error("more than one status flag raised with ack");

    // first edge after reset release
    reset_quiet: assert property (
        @(posedge clk) $fell(reset_i) |-> (!ack_i && flags_i == 4'b0)
    ) else $error("ack or a status flag high right after reset");

endmodule

bind hash_table hash_table_asserts u_asserts (
    .clk    (clk),
    .reset_i(reset_i),
    .cyc_i  (wb_cyc_i),
    .stb_i  (wb_stb_i),
    .ack_i  (wb_ack_o),
    .flags_i({no_element_found_o, key_already_present_o,
              no_write_space_o, no_deletion_target_o})
);

// ==== dv/hash_table_tb.sv ====
`timescale 1ns/1ps
`include "hash_table_config.svh"

module hash_table_tb
    import hash_table_pkg::*;
();

    localparam int NT          = `HT_NUM_TABLES;
    localparam int NB          = 1 << `HT_ADR_W;
    localparam int MATRIX_W    = NT * `HT_KEY_W * `HT_ADR_W;
    localparam int ACK_TIMEOUT = 20;
    localparam int POOL_SIZE   = 96;

    logic  clk;
    logic  reset_i;
    logic  wb_cyc_i;
    logic  wb_stb_i;
    key_t  wb_adr_i;
    data_t wb_dat_i;
    op_t   op_i;
    logic  wb_ack_o;
    data_t wb_dat_o;
    logic  no_element_found_o;
    logic  key_already_present_o;
    logic  no_write_space_o;
    logic  no_deletion_target_o;

    int          check_count;
    int          err_count;
    int          timeout_count;
    bit          aborted;
    int          n;
    int          tries;
    int unsigned sel;
    bit          found;
    key_t        k;
    key_t        victim;
    data_t       d;
    key_t        pool [POOL_SIZE];
    bit          seen [key_t];
    data_t       store [key_t];     // reference contents
    bit          occ [NT][NB];      // bucket occupancy per table
    key_t        occ_key [NT][NB];

    hash_table dut_i (
        .clk                  (clk),
        .reset_i              (reset_i),
        .wb_cyc_i             (wb_cyc_i),
        .wb_stb_i             (wb_stb_i),
        .wb_adr_i             (wb_adr_i),
        .wb_dat_i             (wb_dat_i),
        .op_i                 (op_i),
        .wb_ack_o             (wb_ack_o),
        .wb_dat_o             (wb_dat_o),
        .no_element_found_o   (no_element_found_o),
        .key_already_present_o(key_already_present_o),
        .no_write_space_o     (no_write_space_o),
        .no_deletion_target_o (no_deletion_target_o)
    );

    always #5 clk = ~clk;

    // XOR of the matrix rows of table t picked by the set key bits
    function automatic bucket_adr_t bucket_of(input int t, input key_t key);
        logic [MATRIX_W-1:0] m;
        bucket_adr_t         h;
        m = `HT_H3_MATRIX;
        h = '0;
        for (int r = 0; r < `HT_KEY_W; r++) begin
            if (key[r]) begin
                h ^= m[(t * `HT_KEY_W + r) * `HT_ADR_W +: `HT_ADR_W];
            end
        end
        return h;
    endfunction

    function automatic int holding_table(input key_t key);
        for (int t = 0; t < NT; t++) begin
            if (occ[t][bucket_of(t, key)] && occ_key[t][bucket_of(t, key)] == key) begin
                return t;
            end
        end
        return -1;
    endfunction

    function automatic int free_table(input key_t key);
        for (int t = 0; t < NT; t++) begin
            if (!occ[t][bucket_of(t, key)]) begin
                return t;   // lowest free table
            end
        end
        return -1;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            err_count++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic do_op(input string name, input op_t op, input key_t key, input data_t dat);
        logic [3:0] exp_flags;
        data_t      exp_dat;
        int         hold;
        int         free_t;
        int         cycles;
        if (aborted) begin
            return;
        end
        hold      = holding_table(key);
        free_t    = free_table(key);
        exp_dat   = '0;
        exp_flags = '0;
        case (op)
            OP_READ: begin
                if (hold >= 0) begin
                    exp_dat = store[key];
                end else begin
                    exp_flags[3] = 1'b1;
                end
            end
            OP_WRITE: begin
                if (hold >= 0) begin
                    exp_flags[2] = 1'b1;
                end else if (free_t < 0) begin
                    exp_flags[1] = 1'b1;
                end
            end
            OP_DELETE: exp_flags[0] = (hold < 0);
            default: ;
        endcase
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_adr_i = key;
        wb_dat_i = dat;
        op_i     = op;
        cycles   = 0;
        while (!wb_ack_o && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (!wb_ack_o) begin
            $display("timeout: %s got no acknowledge within %0d cycles", name, ACK_TIMEOUT);
            timeout_count++;
            aborted  = 1'b1;
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            return;
        end
        check({name, " ack delay"}, 32'd3, 32'(cycles));
        check({name, " data"}, exp_dat, wb_dat_o);
        check({name, " flags"}, 32'(exp_flags), 32'({no_element_found_o,
              key_already_present_o, no_write_space_o, no_deletion_target_o}));
        if (op == OP_WRITE && hold < 0 && free_t >= 0) begin
            occ[free_t][bucket_of(free_t, key)]     = 1'b1;
            occ_key[free_t][bucket_of(free_t, key)] = key;
            store[key]                              = dat;
        end else if (op == OP_DELETE && hold >= 0) begin
            occ[hold][bucket_of(hold, key)] = 1'b0;
            store.delete(key);
        end
        @(posedge clk);   // stb stays up through the ack cycle
        @(negedge clk);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        op_i     = OP_NONE;
        check({name, " idle outputs"}, 32'd0, 32'({wb_ack_o, wb_dat_o != '0,
              no_element_found_o, key_already_present_o, no_write_space_o,
              no_deletion_target_o}));
    endtask

    initial begin
        void'($urandom(33590));
        clk      = 1'b0;
        reset_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        op_i     = OP_NONE;
        n = 0;
        while (n < POOL_SIZE) begin
            k = 16'($urandom);
            if (!seen.exists(k)) begin
                seen[k] = 1'b1;
                pool[n] = k;
                n++;
            end
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        do_op("read absent", OP_READ, pool[0], '0);
        do_op("delete absent", OP_DELETE, pool[0], '0);
        d = $urandom;
        do_op("write new", OP_WRITE, pool[1], d);
        do_op("read new", OP_READ, pool[1], '0);
        do_op("write present", OP_WRITE, pool[1], ~d);
        do_op("read unchanged", OP_READ, pool[1], '0);

        // fill until some key finds all of its buckets taken
        found = 1'b0;
        tries = 0;
        while (!found && tries < 400 && !aborted) begin
            k = pool[$urandom_range(POOL_SIZE - 1)];
            if (holding_table(k) < 0 && free_table(k) < 0) begin
                found = 1'b1;
            end else begin
                do_op("fill write", OP_WRITE, k, $urandom);
            end
            tries++;
        end
        if (found) begin
            d = $urandom;
            do_op("write full", OP_WRITE, k, d);
            victim = occ_key[2][bucket_of(2, k)];
            do_op("delete blocker", OP_DELETE, victim, '0);
            do_op("write freed", OP_WRITE, k, d);
            do_op("read freed", OP_READ, k, '0);
        end else if (!aborted) begin
            err_count++;
            $display("filling the tables never produced a key with all buckets occupied");
        end

        for (int i = 0; i < 2000; i++) begin
            k   = pool[$urandom_range(POOL_SIZE - 1)];
            sel = $urandom_range(99);
            if (sel < 40) begin
                do_op($sformatf("random %0d write", i), OP_WRITE, k, $urandom);
            end else if (sel < 75) begin
                do_op($sformatf("random %0d read", i), OP_READ, k, '0);
            end else begin
                do_op($sformatf("random %0d delete", i), OP_DELETE, k, '0);
            end
        end

        $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, err_count,
                 timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hash_table.f ====
+incdir+rtl
rtl/hash_table_pkg.sv
rtl/h3_hash.sv
rtl/bucket_table.sv
rtl/table_controller.sv
rtl/hash_table.sv
dv/hash_table_asserts.sv
dv/hash_table_tb.sv

// ==== rtl/bucket_table.sv ====
`timescale 1ns/1ps
`include "hash_table_config.svh"

module bucket_table
    import hash_table_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,

    input  bucket_adr_t rd_adr_i,
    output entry_t      rd_entry_o,
    output logic        rd_valid_o,

    input  logic        wr_en_i,
    input  bucket_adr_t wr_adr_i,
    input  entry_t      wr_entry_i,
    input  logic        wr_valid_i
);

    localparam int DEPTH = 1 << `HT_ADR_W;

    entry_t           mem [DEPTH];
    logic [DEPTH-1:0] valid_q;

    // entry storage, a delete leaves the old entry in place
    always_ff @(posedge clk) begin
        if (wr_en_i && wr_valid_i) begin
            mem[wr_adr_i] <= wr_entry_i;
        end
        rd_entry_o <= mem[rd_adr_i];   // registered read
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q    <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (wr_en_i) begin
                valid_q[wr_adr_i] <= wr_valid_i;   // set on insert, clear on delete
            end
            rd_valid_o <= valid_q[rd_adr_i];
        end
    end

endmodule

// ==== rtl/h3_hash.sv ====
`timescale 1ns/1ps
`include "hash_table_config.svh"

module h3_hash
    import hash_table_pkg::*;
#(
    parameter int TABLE_IDX = 0
) (
    input  key_t        key_i,
    output bucket_adr_t hash_o
);

    localparam int MATRIX_W = `HT_NUM_TABLES * `HT_KEY_W * `HT_ADR_W;
    localparam int ROW_BASE = TABLE_IDX * `HT_KEY_W;   // first row of this table

    localparam logic [MATRIX_W-1:0] H3_MATRIX = `HT_H3_MATRIX;

    always_comb begin
        hash_o = '0;
        for (int r = 0; r < `HT_KEY_W; r++) begin
            if (key_i[r]) begin
                hash_o = hash_o ^ H3_MATRIX[(ROW_BASE + r) * `HT_ADR_W +: `HT_ADR_W];
            end
        end
    end

endmodule

// ==== rtl/hash_table.sv ====
`timescale 1ns/1ps

module hash_table
    import hash_table_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,

    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  key_t  wb_adr_i,
    input  data_t wb_dat_i,
    input  op_t   op_i,
    output logic  wb_ack_o,
    output data_t wb_dat_o,

    output logic  no_element_found_o,
    output logic  key_already_present_o,
    output logic  no_write_space_o,
    output logic  no_deletion_target_o
);

    localparam int NUM_TABLES = $bits(table_vec_t);

    key_t        key;
    bucket_adr_t hash_adr [NUM_TABLES];
    entry_t      rd_entry [NUM_TABLES];
    table_vec_t  rd_valid;
    table_vec_t  wr_en;
    entry_t      wr_entry;
    logic        wr_valid;

    for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table
        h3_hash #(
            .TABLE_IDX(t)
        ) u_hash (
            .key_i (key),
            .hash_o(hash_adr[t])
        );

        // same bucket address for the lookup and the later write
        bucket_table u_table (
            .clk       (clk),
            .reset_i   (reset_i),
            .rd_adr_i  (hash_adr[t]),
            .rd_entry_o(rd_entry[t]),
            .rd_valid_o(rd_valid[t]),
            .wr_en_i   (wr_en[t]),
            .wr_adr_i  (hash_adr[t]),
            .wr_entry_i(wr_entry),
            .wr_valid_i(wr_valid)
        );
    end

    table_controller u_ctrl (
        .clk                  (clk),
        .reset_i              (reset_i),
        .wb_cyc_i             (wb_cyc_i),
        .wb_stb_i             (wb_stb_i),
        .wb_adr_i             (wb_adr_i),
        .wb_dat_i             (wb_dat_i),
        .op_i                 (op_i),
        .wb_ack_o             (wb_ack_o),
        .wb_dat_o             (wb_dat_o),
        .no_element_found_o   (no_element_found_o),
        .key_already_present_o(key_already_present_o),
        .no_write_space_o     (no_write_space_o),
        .no_deletion_target_o (no_deletion_target_o),
        .key_o                (key),
        .rd_entry_i           (rd_entry),
        .rd_valid_i           (rd_valid),
        .wr_en_o              (wr_en),
        .wr_entry_o           (wr_entry),
        .wr_valid_o           (wr_valid)
    );

endmodule

// ==== rtl/hash_table_config.svh ====
`ifndef HASH_TABLE_CONFIG_SVH
`define HASH_TABLE_CONFIG_SVH

`define HT_KEY_W      16
`define HT_DATA_W     32
`define HT_NUM_TABLES 4
`define HT_ADR_W      4

// H3 matrices for all tables, table 0 in the low 64 bits
// within a table, row r sits at bits [r*HT_ADR_W +: HT_ADR_W] and belongs to key bit r
`define HT_H3_MATRIX { \
    64'h9e3b_71c5_d2a8_4f6b, \
    64'h5c17_e9a3_b64d_28f1, \
    64'ha6d1_3f85_7c2e_b94a, \
    64'h3b8f_d16a_42e7_c59d  \
}

`endif

// ==== rtl/hash_table_pkg.sv ====
`include "hash_table_config.svh"

package hash_table_pkg;

    typedef logic [`HT_KEY_W-1:0]      key_t;
    typedef logic [`HT_DATA_W-1:0]     data_t;
    typedef logic [`HT_ADR_W-1:0]      bucket_adr_t;
    typedef logic [`HT_NUM_TABLES-1:0] table_vec_t;   // one bit per table

    // stored key sits above its data, as in the memory word
    typedef struct packed {
        key_t  key;
        data_t data;
    } entry_t;

    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_READ   = 2'd1,
        OP_WRITE  = 2'd2,
        OP_DELETE = 2'd3
    } op_t;

endpackage

// ==== rtl/table_controller.sv ====
`timescale 1ns/1ps
`include "hash_table_config.svh"

module table_controller
    import hash_table_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,

    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  key_t       wb_adr_i,
    input  data_t      wb_dat_i,
    input  op_t        op_i,
    output logic       wb_ack_o,
    output data_t      wb_dat_o,

    output logic       no_element_found_o,
    output logic       key_already_present_o,
    output logic       no_write_space_o,
    output logic       no_deletion_target_o,

    output key_t       key_o,
    input  entry_t     rd_entry_i [`HT_NUM_TABLES],
    input  table_vec_t rd_valid_i,
    output table_vec_t wr_en_o,
    output entry_t     wr_entry_o,
    output logic       wr_valid_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_RESPOND
    } state_t;

    state_t     state_q;
    logic       rd_ready_q;   // table read data is valid in this cycle
    key_t       key_q;
    data_t      data_q;
    op_t        op_q;

    logic       accept;
    logic       decide;
    table_vec_t hit_vec;
    table_vec_t free_sel;
    logic       any_hit;
    logic       any_free;
    data_t      hit_data;

    assign accept = (state_q == ST_IDLE) && wb_cyc_i && wb_stb_i;
    assign decide = (state_q == ST_LOOKUP) && rd_ready_q;

    // request payload, held for the whole operation
    always_ff @(posedge clk) begin
        if (accept) begin
            key_q  <= wb_adr_i;
            data_q <= wb_dat_i;
            op_q   <= op_i;
        end
    end

    always_comb begin
        hit_data = '0;
        free_sel = '0;
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            hit_vec[t] = rd_valid_i[t] && (rd_entry_i[t].key == key_q);
            if (hit_vec[t]) begin
                hit_data = rd_entry_i[t].data;   // keys are unique, at most one hit
            end
        end
        for (int t = `HT_NUM_TABLES - 1; t >= 0; t--) begin
            if (!rd_valid_i[t]) begin
                free_sel    = '0;
                free_sel[t] = 1'b1;   // lowest free table wins
            end
        end
    end

    assign any_hit  = |hit_vec;
    assign any_free = |free_sel;

    always_comb begin
        wr_en_o    = '0;
        wr_valid_o = 1'b0;
        if (decide) begin
            case (op_q)
                OP_WRITE: begin
                    if (!any_hit) begin
                        wr_en_o    = free_sel;
                        wr_valid_o = 1'b1;
                    end
                end
                OP_DELETE: wr_en_o = hit_vec;   // valid value stays zero
                default: ;
            endcase
        end
    end

    assign wr_entry_o = '{key: key_q, data: data_q};
    assign key_o      = key_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q               <= ST_IDLE;
            rd_ready_q            <= 1'b0;
            wb_dat_o              <= '0;
            no_element_found_o    <= 1'b0;
            key_already_present_o <= 1'b0;
            no_write_space_o      <= 1'b0;
            no_deletion_target_o  <= 1'b0;
        end else begin
            rd_ready_q <= (state_q == ST_LOOKUP) && !rd_ready_q;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (rd_ready_q) begin
                        state_q               <= ST_RESPOND;
                        wb_dat_o              <= (op_q == OP_READ) ? hit_data : '0;
                        no_element_found_o    <= (op_q == OP_READ) && !any_hit;
                        key_already_present_o <= (op_q == OP_WRITE) && any_hit;
                        no_write_space_o      <= (op_q == OP_WRITE) && !any_hit && !any_free;
                        no_deletion_target_o  <= (op_q == OP_DELETE) && !any_hit;
                    end
                end
                ST_RESPOND: begin   // ack cycle, stb still high here
                    state_q               <= ST_IDLE;
                    wb_dat_o              <= '0;
                    no_element_found_o    <= 1'b0;
                    key_already_present_o <= 1'b0;
                    no_write_space_o      <= 1'b0;
                    no_deletion_target_o  <= 1'b0;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign wb_ack_o = (state_q == ST_RESPOND);

endmodule
